// File: project.f
logic/can_err_pkg.sv
logic/axil_regs_pkg.sv
logic/reg_access_if.sv
logic/axil_slave_ctrl.sv
logic/can_bit_monitor.sv
logic/error_status_regs.sv
logic/can_error_detector_top.sv
testbench/tb_can_error_detector.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and decides the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_can_error_detector \
  -f project.f \
  -o sim_tb

# the simulator exits non-zero on a fatal check, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

// File: testbench/tb_can_error_detector.sv
// self-checking testbench with one CAN sample every two clocks and register reads after each group
`timescale 1ns/1ps

module tb_can_error_detector;
  import can_err_pkg::*;
  import axil_regs_pkg::*;

  // expected state of the detector
  typedef struct packed {
    logic       bit_flag;
    logic       stuff_flag;
    err_count_t count;
    logic       prev_bit;
    run_len_t   run;
    logic       clear;
  } model_t;

  logic       s_axi_aclk = 1'b0;
  logic       s_axi_aresetn;
  axil_addr_t s_axi_awaddr;
  logic       s_axi_awvalid;
  logic       s_axi_awready;
  axil_data_t s_axi_wdata;
  axil_strb_t s_axi_wstrb;
  logic       s_axi_wvalid;
  logic       s_axi_wready;
  axil_resp_t s_axi_bresp;
  logic       s_axi_bvalid;
  logic       s_axi_bready;
  axil_addr_t s_axi_araddr;
  logic       s_axi_arvalid;
  logic       s_axi_arready;
  axil_data_t s_axi_rdata;
  axil_resp_t s_axi_rresp;
  logic       s_axi_rvalid;
  logic       s_axi_rready;
  logic       can_rx;
  logic       tx_bit;
  logic       tx_mode;
  logic       bit_sample_point;

  model_t model;
  int     seed = 19;
  int     req_count = 0;
  int     done_count = 0;

  always #20 s_axi_aclk = ~s_axi_aclk;

  can_error_detector_top i_dut (.*);

  function automatic model_t apply_clear(model_t m);
    model_t n;
    n = m;
    n.bit_flag   = 1'b0;
    n.stuff_flag = 1'b0;
    n.count      = '0;
    // the bus idles recessive, so tracking restarts from a high level
    n.prev_bit   = 1'b1;
    n.run        = '0;
    return n;
  endfunction

  function automatic model_t model_sample(model_t m, logic rx, logic txb, logic mode);
    model_t n;
    logic   bit_e;
    logic   stuff_e;
    int     next_run;
    if (m.clear) begin
      return apply_clear(m);
    end
    n = m;
    bit_e = mode && (rx != txb);
    // equal level extends the run and a new level opens one of length 1
    next_run = (rx == m.prev_bit) ? int'(m.run) + 1 : 1;
    stuff_e = (next_run == int'(stuff_limit));
    n.run = stuff_e ? run_len_t'(0) : run_len_t'(next_run);
    n.prev_bit = rx;
    if (bit_e) begin
      n.bit_flag = 1'b1;
    end
    if (stuff_e) begin
      n.stuff_flag = 1'b1;
    end
    // one count per bad sample up to 255
    if ((bit_e || stuff_e) && m.count != err_count_t'(255)) begin
      n.count = m.count + err_count_t'(1);
    end
    return n;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_data(input string name, input axil_data_t expected,
                            input axil_data_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "data compare");
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t expected,
                            input axil_resp_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected 0x%01h actual 0x%01h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "response compare");
    end
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    int cnt;
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    cnt = 0;
    while (!s_axi_awready) begin
      @(posedge s_axi_aclk);
      #2;
      cnt++;
      if (cnt > 100) abort_run("write address handshake hung, awready never rose");
    end
    @(posedge s_axi_aclk);
    #2;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_wvalid  = 1'b1;
    cnt = 0;
    while (!s_axi_wready) begin
      @(posedge s_axi_aclk);
      #2;
      cnt++;
      if (cnt > 100) abort_run("write data handshake hung, wready never rose");
    end
    @(posedge s_axi_aclk);
    #2;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b1;
    cnt = 0;
    while (!s_axi_bvalid) begin
      @(posedge s_axi_aclk);
      #2;
      cnt++;
      if (cnt > 100) abort_run("write response hung, bvalid never rose");
    end
    check_resp("bresp", resp_okay, s_axi_bresp);
    @(posedge s_axi_aclk);
    #2;
    s_axi_bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
    int cnt;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    cnt = 0;
    while (!s_axi_arready) begin
      @(posedge s_axi_aclk);
      #2;
      cnt++;
      if (cnt > 100) abort_run("read address handshake hung, arready never rose");
    end
    @(posedge s_axi_aclk);
    #2;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    cnt = 0;
    while (!s_axi_rvalid) begin
      @(posedge s_axi_aclk);
      #2;
      cnt++;
      if (cnt > 100) abort_run("read data hung, rvalid never rose");
    end
    data = s_axi_rdata;
    check_resp("rresp", resp_okay, s_axi_rresp);
    @(posedge s_axi_aclk);
    #2;
    s_axi_rready = 1'b0;
  endtask

  task automatic compare_registers();
    axil_data_t rdata;
    axil_read(addr_status, rdata);
    check_data("rdata status", axil_data_t'({model.stuff_flag, model.bit_flag}), rdata);
    axil_read(addr_error_count, rdata);
    check_data("rdata error_count", axil_data_t'(model.count), rdata);
    axil_read(addr_control, rdata);
    check_data("rdata control", axil_data_t'(model.clear), rdata);
    // offset 0xC is not mapped
    axil_read(32'h0000_000c, rdata);
    check_data("rdata unmapped", '0, rdata);
  endtask

  // hands a register check to the compare process and waits for it
  task automatic request_check();
    int cnt;
    req_count++;
    cnt = 0;
    while (done_count != req_count) begin
      @(posedge s_axi_aclk);
      #2;
      cnt++;
      if (cnt > 100) abort_run("register check did not finish within 100 cycles");
    end
  endtask

  task automatic drive_sample(input logic rx, input logic txb, input logic mode);
    can_rx           = rx;
    tx_bit           = txb;
    tx_mode          = mode;
    bit_sample_point = 1'b1;
    @(posedge s_axi_aclk);
    #2;
    bit_sample_point = 1'b0;
    model = model_sample(model, rx, txb, mode);
    @(posedge s_axi_aclk);
    #2;
  endtask

  // receive-only run of one level
  task automatic drive_repeat(input logic rx, input int n);
    for (int i = 0; i < n; i++) begin
      drive_sample(rx, rx, 1'b0);
    end
  endtask

  task automatic write_control(input axil_data_t data, input axil_strb_t strb);
    axil_write(addr_control, data, strb);
    if (strb[0]) begin
      model.clear = data[0];
    end
    if (model.clear) begin
      model = apply_clear(model);
    end
  endtask

  initial begin : stimulus
    int   r;
    logic rx;
    s_axi_aresetn    = 1'b0;
    s_axi_awaddr     = '0;
    s_axi_awvalid    = 1'b0;
    s_axi_wdata      = '0;
    s_axi_wstrb      = '0;
    s_axi_wvalid     = 1'b0;
    s_axi_bready     = 1'b0;
    can_rx           = 1'b1;
    tx_bit           = 1'b1;
    tx_mode          = 1'b0;
    bit_sample_point = 1'b0;
    model = apply_clear('0);
    repeat (5) @(posedge s_axi_aclk);
    #2;
    s_axi_aresetn = 1'b1;
    request_check();
    // transmit readback
    drive_sample(1'b0, 1'b1, 1'b1);
    request_check();
    drive_sample(1'b1, 1'b1, 1'b1);
    drive_sample(1'b0, 1'b0, 1'b1);
    drive_sample(1'b1, 1'b0, 1'b0);
    drive_sample(1'b0, 1'b1, 1'b0);
    request_check();
    // stuffing rule
    drive_repeat(1'b1, 6);
    request_check();
    drive_repeat(1'b0, 5);
    drive_sample(1'b1, 1'b1, 1'b0);
    request_check();
    drive_repeat(1'b0, 12);
    request_check();
    // sixth equal bit that also fails readback
    for (int i = 0; i < 5; i++) begin
      drive_sample(1'b0, 1'b0, 1'b1);
    end
    drive_sample(1'b0, 1'b1, 1'b1);
    request_check();
    for (int i = 0; i < 300; i++) begin
      r  = $random(seed);
      rx = r[0];
      drive_sample(rx, ~rx, 1'b1);
    end
    request_check();
    // clear holds everything at zero
    write_control(32'h1, 4'h1);
    request_check();
    drive_sample(1'b0, 1'b1, 1'b1);
    drive_repeat(1'b1, 6);
    request_check();
    write_control(32'h0, 4'h1);
    drive_sample(1'b1, 1'b0, 1'b1);
    request_check();
    write_control(32'h1, 4'he);
    drive_sample(1'b0, 1'b1, 1'b1);
    request_check();
    $display("Regression passed");
    $finish;
  end

  initial begin : compare
    int idle;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    forever begin
      idle = 0;
      // polled between the drive points of the stimulus process
      while (done_count == req_count) begin
        @(posedge s_axi_aclk);
        #1;
        idle++;
        if (idle > 1000) abort_run("no register check was requested for 1000 cycles");
      end
      #1;
      repeat (3) @(posedge s_axi_aclk);
      #2;
      compare_registers();
      #1;
      done_count++;
    end
  end

endmodule

// File: logic/can_error_detector_top.sv
// CAN bit and stuff error detector behind AXI4-Lite; form, CRC and confinement are not covered
`timescale 1ns/1ps

module can_error_detector_top (
  input  logic                    s_axi_aclk,
  input  logic                    s_axi_aresetn,
  input  axil_regs_pkg::axil_addr_t s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  axil_regs_pkg::axil_data_t s_axi_wdata,
  input  axil_regs_pkg::axil_strb_t s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output axil_regs_pkg::axil_resp_t s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  axil_regs_pkg::axil_addr_t s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output axil_regs_pkg::axil_data_t s_axi_rdata,
  output axil_regs_pkg::axil_resp_t s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  input  logic                    can_rx,
  input  logic                    tx_bit,
  input  logic                    tx_mode,
  input  logic                    bit_sample_point
);

  logic bit_err_pulse;
  logic stuff_err_pulse;
  logic clear;

  reg_access_if i_regs_if ();

  axil_slave_ctrl i_axil_slave_ctrl (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .regs          (i_regs_if.ctrl)
  );

  can_bit_monitor i_can_bit_monitor (
    .s_axi_aclk       (s_axi_aclk),
    .s_axi_aresetn    (s_axi_aresetn),
    .can_rx           (can_rx),
    .tx_bit           (tx_bit),
    .tx_mode          (tx_mode),
    .bit_sample_point (bit_sample_point),
    .clear            (clear),
    .bit_err_pulse    (bit_err_pulse),
    .stuff_err_pulse  (stuff_err_pulse)
  );

  error_status_regs i_error_status_regs (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .regs            (i_regs_if.bank),
    .bit_err_pulse   (bit_err_pulse),
    .stuff_err_pulse (stuff_err_pulse),
    .clear           (clear)
  );

endmodule

// File: logic/error_status_regs.sv
// error flags, saturating count and control; clear holds flags and count at zero while set
`timescale 1ns/1ps

module error_status_regs (
  input  logic       s_axi_aclk,
  input  logic       s_axi_aresetn,
  reg_access_if.bank regs,
  input  logic       bit_err_pulse,
  input  logic       stuff_err_pulse,
  output logic       clear
);
  import can_err_pkg::*;
  import axil_regs_pkg::*;

  logic       bit_err_flag;
  logic       stuff_err_flag;
  err_count_t err_count;
  axil_addr_t wr_sel;
  axil_addr_t rd_sel;

  assign wr_sel = regs.wr_addr & addr_decode_mask;
  assign rd_sel = regs.rd_addr & addr_decode_mask;

  // control register, only byte lane 0 is writable
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      clear <= 1'b0;
    end else if (regs.wr_en && wr_sel == addr_control && regs.wr_strb[0]) begin
      clear <= regs.wr_data[0];
    end
  end

  // sticky flags and counter
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      bit_err_flag   <= 1'b0;
      stuff_err_flag <= 1'b0;
      err_count      <= '0;
    end else if (clear) begin
      bit_err_flag   <= 1'b0;
      stuff_err_flag <= 1'b0;
      err_count      <= '0;
    end else begin
      if (bit_err_pulse) begin
        bit_err_flag <= 1'b1;
      end
      if (stuff_err_pulse) begin
        stuff_err_flag <= 1'b1;
      end
      // one count per erroneous sample, stops at 255
      if ((bit_err_pulse || stuff_err_pulse) && err_count != '1) begin
        err_count <= err_count + err_count_t'(1);
      end
    end
  end

  // read mux
  always_comb begin
    case (rd_sel)
      addr_status:      regs.rd_data = axil_data_t'({stuff_err_flag, bit_err_flag});
      addr_error_count: regs.rd_data = axil_data_t'(err_count);
      addr_control:     regs.rd_data = axil_data_t'(clear);
      default:          regs.rd_data = '0;
    endcase
  end

  // the count only drops through the clear path
  assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    (err_count < $past(err_count)) |-> $past(clear));

endmodule

// File: logic/can_bit_monitor.sv
// checks each sampled CAN bit; bit_sample_point must be a one-cycle pulse per bit time
`timescale 1ns/1ps

module can_bit_monitor (
  input  logic s_axi_aclk,
  input  logic s_axi_aresetn,
  input  logic can_rx,
  input  logic tx_bit,
  input  logic tx_mode,
  input  logic bit_sample_point,
  input  logic clear,
  output logic bit_err_pulse,
  output logic stuff_err_pulse
);
  import can_err_pkg::*;

  logic     prev_bit;
  logic     same_bit;
  run_len_t run_len;
  run_len_t run_inc;

  assign same_bit = (can_rx == prev_bit);
  assign run_inc  = run_len + run_len_t'(1);

  // run tracking over consecutive samples
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      prev_bit        <= 1'b1;
      run_len         <= '0;
      stuff_err_pulse <= 1'b0;
    end else if (clear) begin
      prev_bit        <= 1'b1;
      run_len         <= '0;
      stuff_err_pulse <= 1'b0;
    end else begin
      stuff_err_pulse <= 1'b0;
      if (bit_sample_point) begin
        prev_bit <= can_rx;
        if (!same_bit) begin
          run_len <= run_len_t'(1);
        end else if (run_inc == stuff_limit) begin
          // sixth equal bit, the next one starts a fresh run
          stuff_err_pulse <= 1'b1;
          run_len         <= '0;
        end else begin
          run_len <= run_inc;
        end
      end
    end
  end

  // transmitter readback compare
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      bit_err_pulse <= 1'b0;
    end else begin
      bit_err_pulse <= bit_sample_point && tx_mode && (can_rx != tx_bit);
    end
  end

  // a bit error only follows a sample taken while transmitting
  assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    bit_err_pulse |-> $past(tx_mode && bit_sample_point));

endmodule

// File: logic/axil_slave_ctrl.sv
// AXI4-Lite slave, one transaction per channel at a time; all responses are OKAY
`timescale 1ns/1ps

module axil_slave_ctrl (
  input  logic                    s_axi_aclk,
  input  logic                    s_axi_aresetn,
  input  axil_regs_pkg::axil_addr_t s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  axil_regs_pkg::axil_data_t s_axi_wdata,
  input  axil_regs_pkg::axil_strb_t s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output axil_regs_pkg::axil_resp_t s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  axil_regs_pkg::axil_addr_t s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output axil_regs_pkg::axil_data_t s_axi_rdata,
  output axil_regs_pkg::axil_resp_t s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  reg_access_if.ctrl              regs
);
  import axil_regs_pkg::*;

  typedef enum logic [1:0] {
    wr_idle,
    wr_wait_data,
    wr_commit,
    wr_resp
  } wr_state_t;

  typedef enum logic [1:0] {
    rd_idle,
    rd_capture,
    rd_resp
  } rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;

  // no slave errors in this block
  assign s_axi_bresp = resp_okay;
  assign s_axi_rresp = resp_okay;

  // write channel FSM
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      wr_state      <= wr_idle;
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      regs.wr_en    <= 1'b0;
    end else begin
      regs.wr_en <= 1'b0;
      case (wr_state)
        wr_idle: begin
          if (s_axi_awvalid) begin
            s_axi_awready <= 1'b1;
            wr_state      <= wr_wait_data;
          end
        end
        wr_wait_data: begin
          s_axi_awready <= 1'b0;
          if (s_axi_wvalid) begin
            s_axi_wready <= 1'b1;
            wr_state     <= wr_commit;
          end
        end
        wr_commit: begin
          // data accepted, hand it to the bank and respond
          s_axi_wready <= 1'b0;
          regs.wr_en   <= 1'b1;
          s_axi_bvalid <= 1'b1;
          wr_state     <= wr_resp;
        end
        wr_resp: begin
          if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            wr_state     <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // write payload, captured in step with the handshakes
  always_ff @(posedge s_axi_aclk) begin
    if (wr_state == wr_idle && s_axi_awvalid) begin
      regs.wr_addr <= s_axi_awaddr;
    end
    if (wr_state == wr_wait_data && s_axi_wvalid) begin
      regs.wr_data <= s_axi_wdata;
      regs.wr_strb <= s_axi_wstrb;
    end
  end

  // read channel FSM
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rd_state      <= rd_idle;
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (s_axi_arvalid) begin
            s_axi_arready <= 1'b1;
            rd_state      <= rd_capture;
          end
        end
        rd_capture: begin
          s_axi_arready <= 1'b0;
          s_axi_rvalid  <= 1'b1;
          rd_state      <= rd_resp;
        end
        rd_resp: begin
          if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            rd_state     <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  // read address and returned data
  always_ff @(posedge s_axi_aclk) begin
    if (rd_state == rd_idle && s_axi_arvalid) begin
      regs.rd_addr <= s_axi_araddr;
    end
    if (rd_state == rd_capture) begin
      s_axi_rdata <= regs.rd_data;
    end
  end

  // responses wait for the master
  assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

  assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid);

  // address and data phases are taken one after the other
  assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    !(s_axi_awready && s_axi_wready));

endmodule

// File: logic/reg_access_if.sv
// register access between bus controller and register bank; rd_data is combinational
`timescale 1ns/1ps

interface reg_access_if;
  import axil_regs_pkg::*;

  // write side, held stable while wr_en pulses
  logic       wr_en;
  axil_addr_t wr_addr;
  axil_data_t wr_data;
  axil_strb_t wr_strb;

  // read side
  axil_addr_t rd_addr;
  axil_data_t rd_data;

  modport ctrl (
    output wr_en, wr_addr, wr_data, wr_strb, rd_addr,
    input  rd_data
  );

  modport bank (
    input  wr_en, wr_addr, wr_data, wr_strb, rd_addr,
    output rd_data
  );

endinterface

// File: logic/axil_regs_pkg.sv
// AXI4-Lite register map; only address bits 3:2 are decoded, so the map repeats every 16 bytes
package axil_regs_pkg;

  // bus widths
  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [1:0]  axil_resp_t;

  // register offsets
  // status: bit 0 bit error, bit 1 stuff error, bits 3:2 reserved
  localparam axil_addr_t addr_status      = 32'h0000_0000;
  // error count in bits 7:0
  localparam axil_addr_t addr_error_count = 32'h0000_0004;
  // control: bit 0 clear
  localparam axil_addr_t addr_control     = 32'h0000_0008;

  // address bits taken into the register decode
  localparam axil_addr_t addr_decode_mask = 32'h0000_000C;

  // every access answers OKAY
  localparam axil_resp_t resp_okay = 2'b00;

endpackage

// File: logic/can_err_pkg.sv
// CAN error widths; the run length type is 3 bits, so stuff_limit must stay below 8
package can_err_pkg;

  // count of equal consecutive samples on the bus
  typedef logic [2:0] run_len_t;

  // saturating error counter, read back in bits 7:0
  typedef logic [7:0] err_count_t;

  // six equal bits in a row break the CAN stuffing rule
  localparam run_len_t stuff_limit = 3'd6;

endpackage
